// File: build.f
rtl/frame_pkg.sv
rtl/axis_frame_fifo.sv
rtl/frame_arbiter.sv
rtl/frame_stats_wb.sv
rtl/frame_agg_top.sv
verif/frame_agg_sva.sv
verif/frame_agg_tb.sv

// File: rtl/axis_frame_fifo.sv
`timescale 1ns/1ps

module axis_frame_fifo #(
  parameter int FIFO_ADDR_W = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [frame_pkg::DATA_W-1:0] s_tdata,
  input  logic                         s_tvalid,
  output logic                         s_tready,
  input  logic                         s_tlast,
  input  logic                         s_tuser,
  output logic [frame_pkg::DATA_W-1:0] m_tdata,
  output logic                         m_tvalid,
  input  logic                         m_tready,
  output logic                         m_tlast,
  output logic                         stat_good,
  output logic                         stat_bad,
  output logic                         stat_ovf
);

  localparam int WIDTH = frame_pkg::DATA_W + 1; // tlast stored above tdata

  logic [WIDTH-1:0]       mem [2**FIFO_ADDR_W];
  logic [FIFO_ADDR_W:0]   wr_ptr;               // Committed frames end here
  logic [FIFO_ADDR_W:0]   wr_ptr_next;
  logic [FIFO_ADDR_W:0]   wr_cur;               // Frame being written
  logic [FIFO_ADDR_W:0]   wr_cur_next;
  logic [FIFO_ADDR_W-1:0] wr_addr;
  logic [FIFO_ADDR_W:0]   rd_ptr;
  logic [FIFO_ADDR_W:0]   rd_ptr_next;
  logic [WIDTH-1:0]       rd_data;
  logic                   rd_valid;
  logic                   rd_valid_next;
  logic [WIDTH-1:0]       out_data;
  logic                   out_valid;
  logic                   out_valid_next;
  logic                   accept_en;
  logic                   drop;
  logic                   drop_next;
  logic                   good_next;
  logic                   bad_next;
  logic                   ovf_next;
  logic                   write;
  logic                   read;
  logic                   store;
  logic                   full_cur;
  logic                   empty;

  assign full_cur = (wr_cur[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                    (wr_cur[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);
  assign empty    = (wr_ptr == rd_ptr);

  assign s_tready = accept_en; // Full frames are dropped rather than stalled
  assign m_tdata  = out_data[frame_pkg::DATA_W-1:0];
  assign m_tlast  = out_data[frame_pkg::DATA_W];
  assign m_tvalid = out_valid;

  always_comb begin
    write       = 1'b0;
    drop_next   = drop;
    good_next   = 1'b0;
    bad_next    = 1'b0;
    ovf_next    = 1'b0;
    wr_ptr_next = wr_ptr;
    wr_cur_next = wr_cur;
    if (s_tvalid && s_tready) begin
      if (full_cur || drop) begin
        drop_next = 1'b1;
        if (s_tlast) begin
          wr_cur_next = wr_ptr; // Rewind over the partial frame
          drop_next   = 1'b0;
          ovf_next    = 1'b1;
        end
      end else begin
        write       = 1'b1;
        wr_cur_next = wr_cur + 1'b1;
        if (s_tlast) begin
          if (s_tuser == frame_pkg::BAD_USER) begin
            wr_cur_next = wr_ptr;
            bad_next    = 1'b1;
          end else begin
            wr_ptr_next = wr_cur + 1'b1; // Commit whole frame
            good_next   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      accept_en <= 1'b0;
      wr_ptr    <= '0;
      wr_cur    <= '0;
      wr_addr   <= '0;
      drop      <= 1'b0;
      stat_good <= 1'b0;
      stat_bad  <= 1'b0;
      stat_ovf  <= 1'b0;
    end else begin
      accept_en <= 1'b1;
      wr_ptr    <= wr_ptr_next;
      wr_cur    <= wr_cur_next;
      wr_addr   <= wr_cur_next[FIFO_ADDR_W-1:0];
      drop      <= drop_next;
      stat_good <= good_next;
      stat_bad  <= bad_next;
      stat_ovf  <= ovf_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_addr] <= {s_tlast, s_tdata};
    end
  end

  // Read pipeline of memory register then output register
  always_comb begin
    read          = 1'b0;
    rd_ptr_next   = rd_ptr;
    rd_valid_next = rd_valid;
    if (store || !rd_valid) begin
      if (!empty) begin
        read          = 1'b1;
        rd_valid_next = 1'b1;
        rd_ptr_next   = rd_ptr + 1'b1;
      end else begin
        rd_valid_next = 1'b0;
      end
    end
  end

  assign store          = m_tready || !out_valid;
  assign out_valid_next = store ? rd_valid : out_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr    <= '0;
      rd_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      rd_ptr    <= rd_ptr_next;
      rd_valid  <= rd_valid_next;
      out_valid <= out_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rd_data <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
    end
    if (store) begin
      out_data <= rd_data;
    end
  end

endmodule

// File: rtl/frame_agg_top.sv
`timescale 1ns/1ps

module frame_agg_top #(
  parameter int FIFO_ADDR_W = 4
) (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic [frame_pkg::PORTS-1:0][frame_pkg::DATA_W-1:0] s_tdata,
  input  logic [frame_pkg::PORTS-1:0]                        s_tvalid,
  output logic [frame_pkg::PORTS-1:0]                        s_tready,
  input  logic [frame_pkg::PORTS-1:0]                        s_tlast,
  input  logic [frame_pkg::PORTS-1:0]                        s_tuser,
  output logic [frame_pkg::DATA_W-1:0]                       m_tdata,
  output logic                                              m_tvalid,
  input  logic                                              m_tready,
  output logic                                              m_tlast,
  output logic [frame_pkg::PORT_W-1:0]                       m_tid,
  input  logic                                              wb_cyc,
  input  logic                                              wb_stb,
  input  logic                                              wb_we,
  input  logic [frame_pkg::WB_ADR_W-1:0]                     wb_adr,
  input  logic [frame_pkg::CNT_W-1:0]                        wb_dat_w,
  output logic [frame_pkg::CNT_W-1:0]                        wb_dat_r,
  output logic                                              wb_ack
);

  logic [frame_pkg::PORTS-1:0][frame_pkg::DATA_W-1:0] q_tdata;
  logic [frame_pkg::PORTS-1:0]                        q_tvalid;
  logic [frame_pkg::PORTS-1:0]                        q_tready;
  logic [frame_pkg::PORTS-1:0]                        q_tlast;
  logic [frame_pkg::PORTS-1:0]                        st_good;
  logic [frame_pkg::PORTS-1:0]                        st_bad;
  logic [frame_pkg::PORTS-1:0]                        st_ovf;

  for (genvar p = 0; p < frame_pkg::PORTS; p++) begin : g_port
    axis_frame_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) fifo_i (
      .clk(clk), .rst(rst),
      .s_tdata(s_tdata[p]), .s_tvalid(s_tvalid[p]), .s_tready(s_tready[p]),
      .s_tlast(s_tlast[p]), .s_tuser(s_tuser[p]),
      .m_tdata(q_tdata[p]), .m_tvalid(q_tvalid[p]), .m_tready(q_tready[p]),
      .m_tlast(q_tlast[p]),
      .stat_good(st_good[p]), .stat_bad(st_bad[p]), .stat_ovf(st_ovf[p])
    );
  end

  frame_arbiter #(.PORTS(frame_pkg::PORTS)) arb_i (
    .clk(clk), .rst(rst),
    .in_tdata(q_tdata), .in_tvalid(q_tvalid), .in_tready(q_tready), .in_tlast(q_tlast),
    .m_tdata(m_tdata), .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tlast(m_tlast),
    .m_tid(m_tid)
  );

  frame_stats_wb #(.PORTS(frame_pkg::PORTS)) stats_i (
    .clk(clk), .rst(rst),
    .good(st_good), .bad(st_bad), .ovf(st_ovf),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

endmodule

// File: rtl/frame_arbiter.sv
`timescale 1ns/1ps

module frame_arbiter #(
  parameter int PORTS = 2
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [PORTS-1:0][frame_pkg::DATA_W-1:0] in_tdata,
  input  logic [PORTS-1:0]                        in_tvalid,
  output logic [PORTS-1:0]                        in_tready,
  input  logic [PORTS-1:0]                        in_tlast,
  output logic [frame_pkg::DATA_W-1:0]            m_tdata,
  output logic                                    m_tvalid,
  input  logic                                    m_tready,
  output logic                                    m_tlast,
  output logic [frame_pkg::PORT_W-1:0]            m_tid
);

  localparam int LAST_INIT = PORTS - 1; // Port 0 is served first after reset

  logic [frame_pkg::PORT_W-1:0] grant;
  logic [frame_pkg::PORT_W-1:0] last_port;
  logic [frame_pkg::PORT_W-1:0] pick;
  logic                         pick_found;
  logic                         locked;
  logic                         xfer_last;

  // Next valid port after the last served one
  always_comb begin
    int cand;
    pick       = last_port;
    pick_found = 1'b0;
    for (int i = PORTS; i >= 1; i--) begin
      cand = (int'(last_port) + i) % PORTS;
      if (in_tvalid[cand]) begin
        pick       = cand[frame_pkg::PORT_W-1:0];
        pick_found = 1'b1;
      end
    end
  end

  assign m_tvalid  = locked && in_tvalid[grant];
  assign m_tdata   = in_tdata[grant];
  assign m_tlast   = in_tlast[grant];
  assign m_tid     = grant;
  assign xfer_last = m_tvalid && m_tready && m_tlast;

  always_comb begin
    for (int p = 0; p < PORTS; p++) begin
      in_tready[p] = locked && (int'(grant) == p) && m_tready; // Only the granted FIFO moves
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      locked    <= 1'b0;
      grant     <= '0;
      last_port <= LAST_INIT[frame_pkg::PORT_W-1:0];
    end else if (!locked) begin
      if (pick_found) begin
        grant  <= pick;
        locked <= 1'b1;
      end
    end else if (xfer_last) begin
      locked    <= 1'b0; // Rearbitrate next cycle
      last_port <= grant;
    end
  end

endmodule

// File: rtl/frame_pkg.sv
package frame_pkg;

  // Stream payload
  localparam int DATA_W = 8;

  // Source ports and the tid that names them
  localparam int PORTS  = 2;
  localparam int PORT_W = 1;

  // Status counters and bus
  localparam int CNT_W    = 16;
  localparam int WB_ADR_W = 3;

  // Counter kinds at address port * 4 + kind
  localparam int STAT_GOOD = 0;
  localparam int STAT_BAD  = 1;
  localparam int STAT_OVF  = 2;

  // tuser on the last beat of a bad frame
  localparam logic BAD_USER = 1'b1;

endpackage

// File: rtl/frame_stats_wb.sv
`timescale 1ns/1ps

module frame_stats_wb #(
  parameter int PORTS = 2
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [PORTS-1:0]               good,
  input  logic [PORTS-1:0]               bad,
  input  logic [PORTS-1:0]               ovf,
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [frame_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [frame_pkg::CNT_W-1:0]    wb_dat_w, // Any write clears
  output logic [frame_pkg::CNT_W-1:0]    wb_dat_r,
  output logic                           wb_ack
);

  localparam int KINDS = 3;

  logic [frame_pkg::CNT_W-1:0]    cnt [PORTS][KINDS];
  logic [KINDS-1:0]               pulse [PORTS];
  logic [frame_pkg::WB_ADR_W-3:0] sel_port;
  logic [1:0]                     sel_kind;
  logic [frame_pkg::CNT_W-1:0]    rd_val;
  logic                           req;

  assign req      = wb_cyc && wb_stb && !wb_ack; // One ack per strobe
  assign sel_port = wb_adr[frame_pkg::WB_ADR_W-1:2];
  assign sel_kind = wb_adr[1:0];

  always_comb begin
    for (int p = 0; p < PORTS; p++) begin
      pulse[p][frame_pkg::STAT_GOOD] = good[p];
      pulse[p][frame_pkg::STAT_BAD]  = bad[p];
      pulse[p][frame_pkg::STAT_OVF]  = ovf[p];
    end
  end

  // Unmapped addresses read zero
  always_comb begin
    rd_val = '0;
    for (int p = 0; p < PORTS; p++) begin
      for (int k = 0; k < KINDS; k++) begin
        if (int'(sel_port) == p && int'(sel_kind) == k) begin
          rd_val = cnt[p][k];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      for (int p = 0; p < PORTS; p++) begin
        for (int k = 0; k < KINDS; k++) begin
          cnt[p][k] <= '0;
        end
      end
    end else begin
      wb_ack <= req;
      for (int p = 0; p < PORTS; p++) begin
        for (int k = 0; k < KINDS; k++) begin
          if (req && wb_we && int'(sel_port) == p && int'(sel_kind) == k) begin
            cnt[p][k] <= '0; // Clear beats a same-cycle pulse
          end else if (pulse[p][k] && cnt[p][k] != '1) begin
            cnt[p][k] <= cnt[p][k] + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      wb_dat_r <= rd_val;
    end
  end

endmodule

// File: verif/frame_agg_sva.sv
`timescale 1ns/1ps

module frame_agg_sva #(
  parameter int PORTS = 2
) (
  input logic                           clk,
  input logic                           rst,
  input logic [PORTS-1:0]               in_tready,
  input logic [frame_pkg::DATA_W-1:0]   m_tdata,
  input logic                           m_tvalid,
  input logic                           m_tready,
  input logic                           m_tlast,
  input logic [frame_pkg::PORT_W-1:0]   m_tid
);

  logic mid_frame; // First beat gone, last beat not yet

  always_ff @(posedge clk) begin
    if (rst) begin
      mid_frame <= 1'b0;
    end else if (m_tvalid && m_tready) begin
      mid_frame <= !m_tlast;
    end
  end

  hold_a: assert property (@(posedge clk) disable iff (rst)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
    else $error("Output beat changed while stalled");

  one_ready_a: assert property (@(posedge clk) disable iff (rst) $onehot0(in_tready))
    else $error("More than one FIFO sees ready");

  tid_a: assert property (@(posedge clk) disable iff (rst) mid_frame |-> $stable(m_tid))
    else $error("m_tid changed inside a frame");

endmodule

bind frame_arbiter frame_agg_sva #(.PORTS(PORTS)) sva_i (
  .clk(clk),
  .rst(rst),
  .in_tready(in_tready),
  .m_tdata(m_tdata),
  .m_tvalid(m_tvalid),
  .m_tready(m_tready),
  .m_tlast(m_tlast),
  .m_tid(m_tid)
);

// File: verif/frame_agg_tb.sv
`timescale 1ns/1ps

module frame_agg_tb;

  localparam int DEPTH     = 16;
  localparam int MAX_BEATS = 20 * 8 + 20 * 8 + 3 * (24 + 8) + 60 * 8; // Worst case over all tests

  logic                                              clk = 1'b0;
  logic                                              rst;
  logic [frame_pkg::PORTS-1:0][frame_pkg::DATA_W-1:0] s_tdata;
  logic [frame_pkg::PORTS-1:0]                        s_tvalid;
  logic [frame_pkg::PORTS-1:0]                        s_tready;
  logic [frame_pkg::PORTS-1:0]                        s_tlast;
  logic [frame_pkg::PORTS-1:0]                        s_tuser;
  logic [frame_pkg::DATA_W-1:0]                       m_tdata;
  logic                                              m_tvalid;
  logic                                              m_tready = 1'b1;
  logic                                              m_tlast;
  logic [frame_pkg::PORT_W-1:0]                       m_tid;
  logic                                              wb_cyc;
  logic                                              wb_stb;
  logic                                              wb_we;
  logic [frame_pkg::WB_ADR_W-1:0]                     wb_adr;
  logic [frame_pkg::CNT_W-1:0]                        wb_dat_w;
  logic [frame_pkg::CNT_W-1:0]                        wb_dat_r;
  logic                                              wb_ack;

  int          seed = 78;
  int          errors;
  int          tests_pass;
  int          tests_fail;
  bit          skip_ok;    // Whole frames may vanish to overflow
  bit          ready_rand;
  int          exp_cnt [frame_pkg::PORTS][3];
  int          dropped [frame_pkg::PORTS];
  logic [71:0] exp_q0 [$]; // {length, up to 8 data bytes}
  logic [71:0] exp_q1 [$];
  logic [63:0] rx_data = '0;
  int          rx_len = 0;
  logic [frame_pkg::PORT_W-1:0] rx_tid;

  frame_agg_top #(.FIFO_ADDR_W(4)) dut_i (.*);

  always #20 clk = ~clk;

  initial begin
    #(MAX_BEATS * 40 * 40);
    $display("Run timed out before all tests finished");
    $display("Test failed");
    $finish;
  end

  always @(posedge clk) begin
    #1;
    m_tready = ready_rand ? 1'($random(seed)) : 1'b1;
  end

  task automatic check_value(input string name, input logic [71:0] got, input logic [71:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic int exp_size(input int p);
    return (p == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  function automatic logic [71:0] exp_pop(input int p);
    return (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
  endfunction

  task automatic match_frame(input int p, input logic [71:0] got);
    logic [71:0] head;
    bit          done;
    done = 1'b0;
    while (!done) begin
      if (exp_size(p) == 0) begin
        $display("Port %0d delivered a frame that was never expected", p);
        errors++;
        done = 1'b1;
      end else begin
        head = exp_pop(p);
        if (head == got || !skip_ok) begin
          check_value("m_tdata frame", got, head);
          done = 1'b1;
          if (skip_ok) exp_cnt[p][frame_pkg::STAT_GOOD]++;
        end else begin
          dropped[p]++; // Lost to overflow
        end
      end
    end
  endtask

  // Output monitor sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && m_tvalid && m_tready) begin
      if (rx_len == 0) begin
        rx_tid = m_tid;
      end else begin
        check_value("m_tid", m_tid, rx_tid);
      end
      if (rx_len < 8) rx_data[rx_len*8 +: 8] = m_tdata;
      rx_len++;
      if (m_tlast) begin
        match_frame(rx_tid, {8'(rx_len), rx_data});
        rx_len  = 0;
        rx_data = '0;
      end
    end
  end

  task automatic send_frame(input int p, input int len, input bit bad);
    logic [71:0] frame;
    frame = '0;
    for (int i = 0; i < len; i++) begin
      s_tdata[p]  = 8'($random(seed));
      s_tvalid[p] = 1'b1;
      s_tlast[p]  = (i == len - 1);
      s_tuser[p]  = bad && (i == len - 1);
      if (i < 8) frame[i*8 +: 8] = s_tdata[p];
      @(negedge clk);
      check_value($sformatf("s_tready[%0d]", p), s_tready[p], 1'b1); // Drops, never stalls
      while (!s_tready[p]) @(negedge clk);
      @(posedge clk);
      #1;
    end
    s_tvalid[p] = 1'b0;
    s_tlast[p]  = 1'b0;
    s_tuser[p]  = 1'b0;
    frame[71:64] = 8'(len);
    if (bad) begin
      exp_cnt[p][frame_pkg::STAT_BAD]++;
    end else if (len > DEPTH) begin
      exp_cnt[p][frame_pkg::STAT_OVF]++; // Can never fit
    end else begin
      if (!skip_ok) exp_cnt[p][frame_pkg::STAT_GOOD]++;
      if (p == 0) exp_q0.push_back(frame);
      else exp_q1.push_back(frame);
    end
  endtask

  task automatic drain();
    int quiet;
    int n;
    quiet = 0;
    n = 0;
    while ((quiet < 8 || (!skip_ok && exp_size(0) + exp_size(1) > 0)) && n < 2000) begin
      @(negedge clk);
      quiet = m_tvalid ? 0 : quiet + 1;
      n++;
    end
    @(posedge clk);
    #1;
    if (n >= 2000) begin
      $display("Expected frames never left the DUT");
      errors++;
    end
    for (int p = 0; p < frame_pkg::PORTS; p++) begin
      while (exp_size(p) > 0) begin
        void'(exp_pop(p));
        dropped[p]++;
      end
    end
  endtask

  task automatic wb_access(input bit we, input int adr, output logic [15:0] data);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr[frame_pkg::WB_ADR_W-1:0];
    wb_dat_w = 16'($random(seed));
    n = 0;
    @(negedge clk);
    while (!wb_ack && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!wb_ack) begin
      $display("Wishbone access to address %0d was never acknowledged", adr);
      errors++;
    end
    data = wb_dat_r;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    if (wb_ack) begin
      $display("Wishbone access to address %0d was acknowledged twice", adr);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_counters(input int p);
    logic [15:0] val;
    for (int k = 0; k < 3; k++) begin
      wb_access(1'b0, p * 4 + k, val);
      check_value($sformatf("wb_dat_r[%0d]", p * 4 + k), val, exp_cnt[p][k]);
    end
  endtask

  task automatic end_test(input string name);
    if (errors == 0) tests_pass++;
    else tests_fail++;
    $display("%s: %0d errors", name, errors);
    errors = 0;
  endtask

  initial begin
    logic [15:0] val;
    rst      = 1'b1;
    s_tdata  = '0;
    s_tvalid = '0;
    s_tlast  = '0;
    s_tuser  = '0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk); // FIFO ready is registered out of reset
    #1;

    for (int i = 0; i < 20; i++) begin
      send_frame(0, 1 + {$random(seed)} % 8, 1'b0);
      drain();
    end
    check_counters(0);
    end_test("test 1 good frames on port 0");

    for (int i = 0; i < 20; i++) begin
      send_frame(1, 1 + {$random(seed)} % 8, ({$random(seed)} % 3) == 0);
      drain();
    end
    check_counters(1);
    end_test("test 2 bad frame dropping on port 1");

    for (int i = 0; i < 3; i++) begin
      send_frame(0, DEPTH + 1 + {$random(seed)} % 8, 1'b0);
      drain();
      send_frame(0, 1 + {$random(seed)} % 8, 1'b0);
      drain();
    end
    check_counters(0);
    end_test("test 3 overflow of long frames");

    skip_ok    = 1'b1;
    ready_rand = 1'b1;
    fork
      begin
        for (int i = 0; i < 30; i++) send_frame(0, 1 + {$random(seed)} % 8, 1'b0);
      end
      begin
        for (int i = 0; i < 30; i++) send_frame(1, 1 + {$random(seed)} % 8, 1'b0);
      end
    join
    ready_rand = 1'b0;
    drain();
    for (int p = 0; p < frame_pkg::PORTS; p++) begin
      exp_cnt[p][frame_pkg::STAT_OVF] += dropped[p]; // Good plus overflow covers every frame sent
      dropped[p] = 0;
      check_counters(p);
    end
    skip_ok = 1'b0;
    end_test("test 4 both ports under back-pressure");

    for (int adr = 0; adr < 8; adr++) begin
      if (adr % 4 != 3) wb_access(1'b1, adr, val);
      wb_access(1'b0, adr, val);
      check_value($sformatf("wb_dat_r[%0d]", adr), val, 0);
    end
    end_test("test 5 Wishbone counter clear");

    $display("Tests passed %0d, failed %0d", tests_pass, tests_fail);
    if (tests_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
